// ==== source/cpuPkg.sv ====
package cpuPkg;

	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;
	localparam int memWords = 256; // testbench memory depth in words

	typedef enum logic [5:0]
	{
		opRtype = 6'b000000,
		opJ = 6'b000010,
		opAddi = 6'b001000,
		opAddiu = 6'b001001,
		opSlti = 6'b001010,
		opXori = 6'b001110,
		opLui = 6'b001111,
		opLw = 6'b100011,
		opSw = 6'b101011
	} opcode_e;

	typedef enum logic [5:0]
	{
		fnRotr = 6'b000010, // srl encoding, rs bit 0 set
		fnSrav = 6'b000111,
		fnAdd = 6'b100000,
		fnSub = 6'b100010,
		fnSubu = 6'b100011,
		fnNor = 6'b100111,
		fnSltu = 6'b101011
	} funct_e;

	typedef enum logic [3:0]
	{
		aluAdd, aluAddu, aluSub, aluSubu,
		aluSlt, aluSltu,
		aluXor, aluNor, aluPassB,
		aluSra, aluRotr
	} aluOp_e;

	typedef enum logic {srcAPc, srcAReg} srcA_e;
	typedef enum logic [1:0] {srcBReg, srcBFour, srcBImm, srcBUpper} srcB_e;
	typedef enum logic {pcAlu, pcJump} pcSrc_e;
	typedef enum logic {wbRes, wbMem} wbSrc_e;
	typedef enum logic {dstRt, dstRd} regDst_e;

	typedef enum logic [2:0]
	{
		stFetch, stDecode, stExecute, stMemAddr, stMemRead, stWriteBack, stMemWrite
	} state_e;

	typedef struct packed
	{
		logic pcWrite;
		logic irWrite;
		logic resWrite;
		srcA_e srcA;
		srcB_e srcB;
		logic signExt; // sign vs zero extension of the immediate
		aluOp_e aluOp;
		logic shiftVar; // shift amount from rs instead of shamt field
		pcSrc_e pcSrc;
		wbSrc_e wbSrc;
		regDst_e regDst;
		logic regWrite;
		logic memWrite;
		logic useResAddr; // memory address from result register
	} ctrl_t;

	typedef struct packed
	{
		logic [dataWidth-1:0] addr;
		logic [dataWidth-1:0] wdata;
		logic we;
	} memReq_t;

	typedef struct packed
	{
		logic en;
		logic [regAddrWidth-1:0] addr;
		logic [dataWidth-1:0] data;
	} regWrite_t;

endpackage

// ==== source/executeUnit.sv ====
`timescale 1ns/1ns

module executeUnit
(
	input logic [cpuPkg::dataWidth-1:0] a,
	input logic [cpuPkg::dataWidth-1:0] b,
	input logic [cpuPkg::regAddrWidth-1:0] shamt,
	input cpuPkg::aluOp_e aluOp,
	output logic [cpuPkg::dataWidth-1:0] result,
	output logic overflow
);
	import cpuPkg::*;

	logic [dataWidth-1:0] sum;
	logic [dataWidth-1:0] diff;
	logic addOv;
	logic subOv;
	logic [2*dataWidth-1:0] doubled;
	logic [dataWidth-1:0] rotated;
	logic [dataWidth-1:0] arith;

	assign sum = a + b;
	assign diff = a - b;

	// signed overflow: operand signs vs result sign
	assign addOv = (a[dataWidth-1] == b[dataWidth-1]) && (sum[dataWidth-1] != a[dataWidth-1]);
	assign subOv = (a[dataWidth-1] != b[dataWidth-1]) && (diff[dataWidth-1] != a[dataWidth-1]);

	assign doubled = {b, b} >> shamt; // rotate via doubled word
	assign rotated = doubled[dataWidth-1:0];
	assign arith = $signed(b) >>> shamt;

	always_comb
	begin
		overflow = 1'b0;
		case (aluOp)
			aluAdd:
			begin
				result = sum;
				overflow = addOv;
			end
			aluAddu: result = sum;
			aluSub:
			begin
				result = diff;
				overflow = subOv;
			end
			aluSubu: result = diff;
			aluSlt: result = {{(dataWidth-1){1'b0}}, $signed(a) < $signed(b)};
			aluSltu: result = {{(dataWidth-1){1'b0}}, a < b};
			aluXor: result = a ^ b;
			aluNor: result = ~(a | b);
			aluPassB: result = b; // lui
			aluSra: result = arith;
			aluRotr: result = rotated;
			default: result = '0;
		endcase
	end

endmodule

// ==== source/registerFile.sv ====
`timescale 1ns/1ns

module registerFile
(
	input logic clk,
	input logic rstN,
	input logic [cpuPkg::regAddrWidth-1:0] rsAddr,
	input logic [cpuPkg::regAddrWidth-1:0] rtAddr,
	input cpuPkg::regWrite_t wr,
	output logic [cpuPkg::dataWidth-1:0] rsData,
	output logic [cpuPkg::dataWidth-1:0] rtData
);
	import cpuPkg::*;

	logic [dataWidth-1:0] regs [2**regAddrWidth];

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < 2**regAddrWidth; i++)
				regs[i] <= '0;
		end
		else if (wr.en && wr.addr != '0)
			regs[wr.addr] <= wr.data; // r0 writes dropped
	end

	assign rsData = regs[rsAddr];
	assign rtData = regs[rtAddr];

	assert property (@(posedge clk) disable iff (!rstN)
		(rsAddr == '0) |-> (rsData == '0));

endmodule

// ==== source/controlFsm.sv ====
`timescale 1ns/1ns

module controlFsm
(
	input logic clk,
	input logic rstN,
	input logic [11:0] instrHead, // opcode and funct
	input logic overflow,
	output cpuPkg::ctrl_t ctrl
);
	import cpuPkg::*;

	state_e state;
	state_e nextState;
	opcode_e opcode;
	funct_e funct;
	logic known; // instruction is in the supported set
	aluOp_e instrOp;
	srcB_e instrSrcB;
	logic instrSignExt;

	assign opcode = opcode_e'(instrHead[11:6]);
	assign funct = funct_e'(instrHead[5:0]);

	// per-instruction ALU operation and operand B source
	always_comb
	begin
		known = 1'b1;
		instrOp = aluAddu;
		instrSrcB = srcBImm;
		instrSignExt = 1'b1;
		case (opcode)
			opRtype:
			begin
				instrSrcB = srcBReg;
				case (funct)
					fnAdd: instrOp = aluAdd;
					fnSub: instrOp = aluSub;
					fnSubu: instrOp = aluSubu;
					fnSltu: instrOp = aluSltu;
					fnNor: instrOp = aluNor;
					fnSrav: instrOp = aluSra;
					fnRotr: instrOp = aluRotr;
					default: known = 1'b0;
				endcase
			end
			opAddi: instrOp = aluAdd;
			opSlti: instrOp = aluSlt;
			opXori:
			begin
				instrOp = aluXor;
				instrSignExt = 1'b0; // logical immediates are zero extended
			end
			opLui:
			begin
				instrOp = aluPassB;
				instrSrcB = srcBUpper;
			end
			opAddiu, opLw, opSw, opJ: instrOp = aluAddu; // lw/sw address add
			default: known = 1'b0;
		endcase
	end

	always_comb
	begin
		nextState = stFetch;
		case (state)
			stFetch: nextState = stDecode;
			stDecode:
			begin
				if (!known)
					nextState = stFetch; // unknown opcode is skipped
				else if (opcode == opLw || opcode == opSw)
					nextState = stMemAddr;
				else
					nextState = stExecute;
			end
			stExecute: nextState = (opcode == opJ) ? stFetch : stWriteBack;
			stMemAddr: nextState = (opcode == opLw) ? stMemRead : stMemWrite;
			stMemRead: nextState = stWriteBack;
			default: nextState = stFetch; // write-back and mem write finish here
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
			state <= stFetch;
		else
			state <= nextState;
	end

	always_comb
	begin
		ctrl = '0;
		ctrl.srcA = srcAReg;
		ctrl.srcB = instrSrcB;
		ctrl.signExt = instrSignExt;
		ctrl.aluOp = instrOp; // held into write-back so overflow stays valid
		ctrl.shiftVar = (funct == fnSrav);
		ctrl.pcSrc = pcAlu;
		ctrl.wbSrc = (opcode == opLw) ? wbMem : wbRes;
		ctrl.regDst = (opcode == opRtype) ? dstRd : dstRt;
		case (state)
			stFetch:
			begin
				ctrl.srcA = srcAPc;
				ctrl.srcB = srcBFour;
				ctrl.aluOp = aluAddu; // pc + 4
				ctrl.pcWrite = 1'b1;
				ctrl.irWrite = 1'b1;
			end
			stExecute:
			begin
				if (opcode == opJ)
				begin
					ctrl.pcSrc = pcJump;
					ctrl.pcWrite = 1'b1;
				end
				else
					ctrl.resWrite = 1'b1;
			end
			stMemAddr: ctrl.resWrite = 1'b1;
			stMemRead: ctrl.useResAddr = 1'b1;
			stMemWrite:
			begin
				ctrl.useResAddr = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			stWriteBack:
			begin
				ctrl.useResAddr = (opcode == opLw);
				ctrl.regWrite = !overflow; // trap on signed overflow
			end
			default: ctrl.resWrite = 1'b0; // decode only settles operands
		endcase
	end

	assert property (@(posedge clk) disable iff (!rstN)
		state inside {stFetch, stDecode, stExecute, stMemAddr, stMemRead, stWriteBack, stMemWrite});

	assert property (@(posedge clk) disable iff (!rstN) !(ctrl.memWrite && ctrl.regWrite));

endmodule

// ==== source/datapath.sv ====
`timescale 1ns/1ns

module datapath
(
	input logic clk,
	input logic rstN,
	input cpuPkg::ctrl_t ctrl,
	input logic [cpuPkg::dataWidth-1:0] memRdata,
	output cpuPkg::memReq_t memReq,
	output cpuPkg::regWrite_t regWr,
	output logic [11:0] instrHead,
	output logic overflow
);
	import cpuPkg::*;

	logic [dataWidth-1:0] pc;
	logic [dataWidth-1:0] ir;
	logic [dataWidth-1:0] res; // ALU result register
	logic [dataWidth-1:0] rsData;
	logic [dataWidth-1:0] rtData;
	logic [dataWidth-1:0] aluA;
	logic [dataWidth-1:0] aluB;
	logic [dataWidth-1:0] aluResult;
	logic [dataWidth-1:0] immExt;
	logic [dataWidth-1:0] nextPc;
	logic [regAddrWidth-1:0] shamt;

	registerFile regFile
	(
		.clk(clk),
		.rstN(rstN),
		.rsAddr(ir[25:21]),
		.rtAddr(ir[20:16]),
		.wr(regWr),
		.rsData(rsData),
		.rtData(rtData)
	);

	executeUnit exec
	(
		.a(aluA),
		.b(aluB),
		.shamt(shamt),
		.aluOp(ctrl.aluOp),
		.result(aluResult),
		.overflow(overflow)
	);

	assign immExt = ctrl.signExt ? {{16{ir[15]}}, ir[15:0]} : {16'h0000, ir[15:0]};

	assign aluA = (ctrl.srcA == srcAPc) ? pc : rsData;

	always_comb
	begin
		case (ctrl.srcB)
			srcBReg: aluB = rtData;
			srcBFour: aluB = 32'd4;
			srcBImm: aluB = immExt;
			default: aluB = {ir[15:0], 16'h0000}; // upper immediate
		endcase
	end

	assign shamt = ctrl.shiftVar ? rsData[regAddrWidth-1:0] : ir[10:6]; // srav vs rotr

	// jump target keeps the region of the incremented pc
	assign nextPc = (ctrl.pcSrc == pcJump) ? {pc[31:28], ir[25:0], 2'b00} : aluResult;

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			pc <= '0;
			ir <= '0;
		end
		else
		begin
			if (ctrl.pcWrite)
				pc <= nextPc;
			if (ctrl.irWrite)
				ir <= memRdata;
		end
	end

	always_ff @(posedge clk)
	begin
		if (ctrl.resWrite)
			res <= aluResult;
	end

	assign instrHead = {ir[31:26], ir[5:0]};

	assign memReq.addr = ctrl.useResAddr ? res : pc; // fetch uses pc
	assign memReq.wdata = rtData;
	assign memReq.we = ctrl.memWrite;

	assign regWr.en = ctrl.regWrite;
	assign regWr.addr = (ctrl.regDst == dstRd) ? ir[15:11] : ir[20:16];
	assign regWr.data = (ctrl.wbSrc == wbMem) ? memRdata : res;

	assert property (@(posedge clk) disable iff (!rstN)
		memReq.we |-> (memReq.addr[1:0] == 2'b00 && memReq.addr < memWords * 4));

endmodule

// ==== source/cpuTop.sv ====
`timescale 1ns/1ns

module cpuTop
(
	input logic clk,
	input logic rstN,
	input logic [cpuPkg::dataWidth-1:0] memRdata, // word at memReq.addr, same cycle
	output cpuPkg::memReq_t memReq,
	output cpuPkg::regWrite_t regWr
);
	import cpuPkg::*;

	ctrl_t ctrl;
	logic [11:0] instrHead;
	logic overflow;

	controlFsm fsm
	(
		.clk(clk),
		.rstN(rstN),
		.instrHead(instrHead),
		.overflow(overflow),
		.ctrl(ctrl)
	);

	datapath dp
	(
		.clk(clk),
		.rstN(rstN),
		.ctrl(ctrl),
		.memRdata(memRdata),
		.memReq(memReq),
		.regWr(regWr),
		.instrHead(instrHead),
		.overflow(overflow)
	);

endmodule

// ==== testbench/isaModel.svh ====
typedef struct packed
{
	logic valid;
	logic isMem; // memory write, else register write
	logic [31:0] addr;
	logic [31:0] data;
	int cycle; // cycle of the strobe, counted from reset release
} wrEvent_t;

logic [31:0] modelPc;
logic [31:0] modelRegs [32];
logic [31:0] modelMem [memWords];
logic [31:0] lfsrState;

// executes one instruction on the architectural copy
function automatic wrEvent_t stepModel(output int cycles);
	logic [31:0] instr;
	logic [31:0] rs;
	logic [31:0] rt;
	logic [31:0] imm;
	logic [32:0] wide;
	logic [31:0] addr;
	int sa;
	wrEvent_t ev;
	instr = modelMem[modelPc[9:2]];
	rs = modelRegs[instr[25:21]];
	rt = modelRegs[instr[20:16]];
	imm = {{16{instr[15]}}, instr[15:0]};
	sa = instr[10:6];
	ev = '0;
	ev.valid = 1'b1;
	ev.addr = 32'(instr[20:16]);
	cycles = 4;
	modelPc = modelPc + 32'd4;
	case (instr[31:26])
		opRtype:
		begin
			ev.addr = 32'(instr[15:11]);
			case (instr[5:0])
				fnAdd:
				begin
					wide = {rs[31], rs} + {rt[31], rt};
					ev.data = wide[31:0];
					ev.valid = (wide[32] == wide[31]); // no write on signed overflow
				end
				fnSub:
				begin
					wide = {rs[31], rs} - {rt[31], rt};
					ev.data = wide[31:0];
					ev.valid = (wide[32] == wide[31]);
				end
				fnSubu: ev.data = rs - rt;
				fnSltu: ev.data = (rs < rt) ? 32'd1 : 32'd0;
				fnNor: ev.data = ~(rs | rt);
				fnSrav: ev.data = $signed(rt) >>> rs[4:0];
				fnRotr: ev.data = (sa == 0) ? rt : ((rt >> sa) | (rt << (32 - sa)));
				default:
				begin
					ev.valid = 1'b0;
					cycles = 2;
				end
			endcase
		end
		opAddi:
		begin
			wide = {rs[31], rs} + {imm[31], imm};
			ev.data = wide[31:0];
			ev.valid = (wide[32] == wide[31]);
		end
		opAddiu: ev.data = rs + imm;
		opSlti: ev.data = ($signed(rs) < $signed(imm)) ? 32'd1 : 32'd0;
		opXori: ev.data = rs ^ {16'h0000, instr[15:0]};
		opLui: ev.data = {instr[15:0], 16'h0000};
		opLw:
		begin
			addr = rs + imm;
			ev.data = modelMem[addr[9:2]];
			cycles = 5;
		end
		opSw:
		begin
			addr = rs + imm;
			ev.isMem = 1'b1;
			ev.addr = addr;
			ev.data = rt;
			modelMem[addr[9:2]] = rt;
		end
		opJ:
		begin
			modelPc = {modelPc[31:28], instr[25:0], 2'b00};
			ev.valid = 1'b0;
			cycles = 3;
		end
		default:
		begin
			ev.valid = 1'b0;
			cycles = 2; // unknown opcode, back to fetch
		end
	endcase
	if (ev.valid && !ev.isMem && ev.addr != 0)
		modelRegs[ev.addr[4:0]] = ev.data;
	return ev;
endfunction

// galois LFSR, one step per bit
function automatic logic [31:0] randBits(int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++)
	begin
		v = {v[30:0], lfsrState[0]};
		lfsrState = (lfsrState >> 1) ^ (lfsrState[0] ? 32'h8020_0003 : 32'h0);
	end
	return v;
endfunction

function automatic logic [31:0] rtypeInstr(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
	logic [4:0] sa, logic [5:0] fn);
	return {6'b000000, rs, rt, rd, sa, fn};
endfunction

function automatic logic [31:0] itypeInstr(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
	logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] jumpInstr(int targetWord);
	return {6'(opJ), 26'(targetWord)};
endfunction

function automatic logic [31:0] randomInstr(int index, int haltIndex);
	logic [4:0] rs;
	logic [4:0] rt;
	logic [4:0] rd;
	logic [15:0] imm;
	logic [15:0] dataAddr;
	int target;
	rs = 5'(randBits(5));
	rt = 5'(randBits(5));
	rd = 5'(randBits(5));
	imm = 16'(randBits(16));
	dataAddr = 16'(32'd768 + 32'd4 * randBits(6)); // data words 192 to 255
	target = index + 1 + int'(randBits(2)); // forward jumps only
	if (target > haltIndex)
		target = haltIndex;
	case (randBits(4))
		0: return rtypeInstr(rs, rt, rd, 5'd0, fnAdd);
		1: return rtypeInstr(rs, rt, rd, 5'd0, fnSub);
		2: return rtypeInstr(rs, rt, rd, 5'd0, fnSubu);
		3: return rtypeInstr(rs, rt, rd, 5'd0, fnSltu);
		4: return rtypeInstr(rs, rt, rd, 5'd0, fnNor);
		5: return rtypeInstr(rs, rt, rd, 5'd0, fnSrav);
		6: return rtypeInstr(5'd1, rt, rd, imm[4:0], fnRotr); // rs bit 0 marks rotate
		7: return itypeInstr(opAddi, rs, rt, imm);
		8: return itypeInstr(opAddiu, rs, rt, imm);
		9: return itypeInstr(opXori, rs, rt, imm);
		10: return itypeInstr(opLui, 5'd0, rt, imm);
		11: return itypeInstr(opSlti, rs, rt, imm);
		12: return itypeInstr(opLw, 5'd0, rt, dataAddr);
		13: return itypeInstr(opSw, 5'd0, rt, dataAddr);
		14: return jumpInstr(target);
		default: return itypeInstr(opLui, 5'd0, rd, imm);
	endcase
endfunction

// ==== testbench/cpuTb.sv ====
`timescale 1ns/1ns

module cpuTb;
	import cpuPkg::*;

	localparam int waitLimit = 4000; // cycles per test

	logic clk;
	logic rstN;
	logic [dataWidth-1:0] memRdata;
	memReq_t memReq;
	regWrite_t regWr;

	`include "isaModel.svh"

	logic [31:0] mem [memWords];
	logic [31:0] prog [$];
	wrEvent_t expected [$];
	wrEvent_t seen;
	wrEvent_t want;
	string testName;
	int testErrors;
	int passedTests;
	int failedTests;
	int edgeCount = 0;
	int releaseEdge = 0;

	cpuTop uut
	(
		.clk(clk),
		.rstN(rstN),
		.memRdata(memRdata),
		.memReq(memReq),
		.regWr(regWr)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	assign memRdata = mem[memReq.addr[9:2]]; // word memory without wait states

	always @(posedge clk)
	begin
		if (memReq.we === 1'b1)
			mem[memReq.addr[9:2]] = memReq.wdata;
	end

	always @(posedge clk)
		edgeCount <= edgeCount + 1;

	function automatic string describe(wrEvent_t e);
		if (e.isMem)
			return $sformatf("mem[%h] = %h", e.addr, e.data);
		return $sformatf("r%0d = %h", e.addr, e.data);
	endfunction

	// strobes are stable mid-cycle
	always @(negedge clk)
	begin
		if (regWr.en === 1'b1 || memReq.we === 1'b1)
		begin
			seen.valid = 1'b1;
			seen.isMem = (memReq.we === 1'b1);
			seen.addr = seen.isMem ? memReq.addr : 32'(regWr.addr);
			seen.data = seen.isMem ? memReq.wdata : regWr.data;
			seen.cycle = edgeCount - releaseEdge + 1;
			if (expected.size() == 0)
			begin
				$display("test %s: write %s seen after the last expected write",
					testName, describe(seen));
				testErrors++;
			end
			else
			begin
				want = expected.pop_front();
				if (seen.isMem !== want.isMem || seen.addr !== want.addr
					|| seen.data !== want.data)
				begin
					$display("Error %s: expected %s, actual %s",
						testName, describe(want), describe(seen));
					testErrors++;
				end
				if (seen.cycle != want.cycle)
				begin
					$display("Error %s: write %s expected in cycle %0d, actual cycle %0d",
						testName, describe(want), want.cycle, seen.cycle);
					testErrors++;
				end
			end
		end
	end

	// loads prog behind reset and checks every write against the model
	task automatic runTest(input string name);
		int waited;
		int total;
		int cycles;
		int steps;
		int writes;
		wrEvent_t ev;
		@(negedge clk);
		rstN = 1'b0;
		testName = name;
		testErrors = 0;
		expected.delete();
		for (int i = 0; i < memWords; i++)
			mem[i] = (32'(i) * 32'h0100_8021) ^ 32'hc3a5_0f00;
		foreach (prog[i])
			mem[i] = prog[i];
		mem[prog.size()] = jumpInstr(prog.size()); // halt loop
		for (int i = 0; i < memWords; i++)
			modelMem[i] = mem[i];
		for (int i = 0; i < 32; i++)
			modelRegs[i] = '0;
		modelPc = '0;
		total = 0;
		steps = 0;
		while (modelPc != 32'(4 * prog.size()) && steps < waitLimit)
		begin
			ev = stepModel(cycles);
			total += cycles;
			steps++;
			if (ev.valid)
			begin
				ev.cycle = total;
				expected.push_back(ev);
			end
		end
		writes = expected.size();
		repeat (8) @(negedge clk);
		rstN = 1'b1;
		releaseEdge = edgeCount;
		waited = 0;
		while (expected.size() > 0 && waited < waitLimit)
		begin
			@(negedge clk);
			waited++;
		end
		if (expected.size() > 0)
		begin
			$display("test %s: timed out after %0d cycles with %0d writes still missing",
				name, waited, expected.size());
			testErrors++;
			expected.delete();
		end
		repeat (12) @(negedge clk); // halt loop must stay silent
		if (testErrors == 0)
		begin
			$display("test %s: passed, %0d writes", name, writes);
			passedTests++;
		end
		else
		begin
			$display("test %s: failed with %0d errors", name, testErrors);
			failedTests++;
		end
	endtask

	initial
	begin
		rstN = 1'b0;
		lfsrState = 32'h7a75_8e15;
		passedTests = 0;
		failedTests = 0;

		prog.delete();
		prog.push_back(itypeInstr(opLui, 5'd0, 5'd1, 16'hf000));
		prog.push_back(itypeInstr(opXori, 5'd1, 5'd1, 16'h1234)); // r1 = f0001234
		prog.push_back(itypeInstr(opLui, 5'd0, 5'd2, 16'h1234));
		prog.push_back(itypeInstr(opXori, 5'd2, 5'd2, 16'hff00)); // r2 = 1234ff00
		prog.push_back(rtypeInstr(5'd1, 5'd2, 5'd3, 5'd0, fnAdd));
		prog.push_back(rtypeInstr(5'd1, 5'd2, 5'd4, 5'd0, fnSub));
		prog.push_back(rtypeInstr(5'd2, 5'd1, 5'd5, 5'd0, fnSubu));
		prog.push_back(rtypeInstr(5'd2, 5'd1, 5'd6, 5'd0, fnSltu));
		prog.push_back(rtypeInstr(5'd1, 5'd2, 5'd7, 5'd0, fnNor));
		prog.push_back(itypeInstr(opAddiu, 5'd0, 5'd8, 16'd5));
		prog.push_back(rtypeInstr(5'd8, 5'd1, 5'd9, 5'd0, fnSrav)); // r1 >>> 5
		prog.push_back(rtypeInstr(5'd1, 5'd2, 5'd10, 5'd12, fnRotr));
		prog.push_back(itypeInstr(opAddiu, 5'd1, 5'd11, 16'hfffd));
		prog.push_back(itypeInstr(opSlti, 5'd1, 5'd12, 16'd7));
		prog.push_back(itypeInstr(opSlti, 5'd2, 5'd13, 16'hffff));
		runTest("aluShift");

		prog.delete();
		prog.push_back(itypeInstr(opLui, 5'd0, 5'd1, 16'h7fff));
		prog.push_back(itypeInstr(opXori, 5'd1, 5'd1, 16'hffff)); // largest positive
		prog.push_back(itypeInstr(opAddi, 5'd1, 5'd2, 16'd1));
		prog.push_back(itypeInstr(opAddiu, 5'd1, 5'd3, 16'd1));
		prog.push_back(rtypeInstr(5'd1, 5'd1, 5'd4, 5'd0, fnAdd));
		prog.push_back(rtypeInstr(5'd1, 5'd0, 5'd5, 5'd0, fnAdd));
		prog.push_back(rtypeInstr(5'd3, 5'd1, 5'd6, 5'd0, fnSub));
		prog.push_back(rtypeInstr(5'd1, 5'd1, 5'd7, 5'd0, fnSub));
		prog.push_back(itypeInstr(opAddi, 5'd1, 5'd8, 16'hffff));
		runTest("overflow");

		prog.delete();
		prog.push_back(itypeInstr(opLui, 5'd0, 5'd1, 16'hdead));
		prog.push_back(itypeInstr(opXori, 5'd1, 5'd1, 16'hbeef));
		prog.push_back(itypeInstr(opSw, 5'd0, 5'd1, 16'd768));
		prog.push_back(itypeInstr(opAddiu, 5'd0, 5'd2, 16'h1357));
		prog.push_back(itypeInstr(opSw, 5'd0, 5'd2, 16'd772));
		prog.push_back(itypeInstr(opLw, 5'd0, 5'd3, 16'd768));
		prog.push_back(itypeInstr(opLw, 5'd0, 5'd4, 16'd772));
		prog.push_back(itypeInstr(opLw, 5'd0, 5'd5, 16'd776)); // untouched fill word
		runTest("memory");

		prog.delete();
		prog.push_back(itypeInstr(opAddiu, 5'd0, 5'd1, 16'd1));
		prog.push_back(jumpInstr(prog.size() + 2));
		prog.push_back(itypeInstr(opAddiu, 5'd0, 5'd2, 16'd2)); // skipped
		prog.push_back(itypeInstr(opAddiu, 5'd0, 5'd3, 16'd3));
		runTest("jump");

		prog.delete();
		prog.push_back(itypeInstr(opAddiu, 5'd0, 5'd1, 16'd9));
		prog.push_back(itypeInstr(opLw, 5'd0, 5'd2, 16'd768));
		prog.push_back(jumpInstr(prog.size() + 1));
		prog.push_back(32'hfc00_0000); // unknown opcode
		prog.push_back(itypeInstr(opSw, 5'd0, 5'd1, 16'd780)); // ends in cycle 18
		runTest("cycleCount");

		for (int n = 0; n < 2; n++)
		begin
			prog.delete();
			for (int i = 0; i < 150; i++)
				prog.push_back(randomInstr(i, 150));
			runTest(n == 0 ? "random1" : "random2");
		end

		$display("%0d tests passed, %0d tests failed", passedTests, failedTests);
		if (failedTests == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== sources.f ====
source/cpuPkg.sv
source/executeUnit.sv
source/registerFile.sv
source/controlFsm.sv
source/datapath.sv
source/cpuTop.sv
testbench/cpuTb.sv
+incdir+testbench

// ==== run.sh ====
#!/bin/bash
# builds the cpu testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module cpuTb -o cpuSim \
	> build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/cpuSim > sim.log 2>&1 || { echo "simulation aborted, see sim.log"; exit 1; }

grep -q "FAIL: see errors above" sim.log && { echo "tests failed, see sim.log"; exit 1; } \
	|| { echo "tests passed"; exit 0; }
